//--- mpeg_host.f
source/mpeg_host_pkg.sv
source/mpeg_word_splitter.sv
source/mpeg_byte_fifo.sv
source/mpeg_start_code_detector.sv
source/mpeg_host_registers.sv
source/mpeg_host_top.sv
testbench/tb_mpeg_host_sva.sv
testbench/tb_mpeg_host.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log for failures

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_mpeg_host \
    -Mdir "$build_dir" -o tb_mpeg_host -f mpeg_host.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/tb_mpeg_host" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -q "ERRORS FOUND" "$log_file"; then
    echo "Simulation failed"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi
echo "Simulation passed"
exit 0

//--- testbench/tb_mpeg_host.sv
`timescale 1ns/10ps

module tb_mpeg_host import mpeg_host_pkg::*; ();
    localparam int dclk_divider = 8;
    localparam int max_cycles   = 20000;   // Whole run needs about 1500 cycles

    logic        clk;
    logic        reset;
    logic [23:1] address;
    bus_word_t   din;
    bus_word_t   dout;
    logic        uds;
    logic        lds;
    logic        write_strobe;
    logic        cs;
    logic        bus_ack;
    logic        intreq;
    logic        intack;
    logic        req;
    logic        ack;
    logic        rdy;
    logic        dtc;
    logic        done_in;
    logic        fifo_overflow;
    integer      seed;
    int          cycle_count = 0;

    // Byte stream 00 00 01 B3 00 00 01 B8 00 00 01 00
    bus_word_t start_code_words [6] = '{16'h0000, 16'h01B3, 16'h0000,
                                        16'h01B8, 16'h0000, 16'h0100};

    mpeg_host_top #(
        .dclk_divider(dclk_divider),
        .fifo_depth(16)
    ) u_dut (
        .clk, .reset, .address, .din, .dout, .uds, .lds, .write_strobe, .cs,
        .bus_ack, .intreq, .intack, .req, .ack, .rdy, .dtc, .done_in, .fifo_overflow
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: run exceeded %0d clock cycles", max_cycles);
            abort_run();
        end
    end

    task automatic abort_run;
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
            abort_run();
        end
    endtask

    task automatic wait_cycles(int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic release_bus;
        cs           = 1'b0;
        uds          = 1'b0;
        lds          = 1'b0;
        write_strobe = 1'b0;
    endtask

    // Returns inside the cycle where bus_ack is high
    task automatic bus_ack_cycle;
        int waited;
        waited = 0;
        do begin
            wait_cycles(1);
            waited++;
        end while (!bus_ack && waited < 8);
        if (!bus_ack) begin
            $display("bus_ack never rose for address 0x%h", address);
            abort_run();
        end
    endtask

    task automatic bus_write(reg_addr_t addr, bus_word_t data);
        address      = {8'h00, addr};
        din          = data;
        write_strobe = 1'b1;
        cs           = 1'b1;
        uds          = 1'b1;
        lds          = 1'b1;
        bus_ack_cycle();
        wait_cycles(1);   // Write lands on this edge
        release_bus();
    endtask

    task automatic bus_read(reg_addr_t addr, output bus_word_t data);
        address      = {8'h00, addr};
        write_strobe = 1'b0;
        cs           = 1'b1;
        uds          = 1'b1;
        lds          = 1'b1;
        bus_ack_cycle();
        data = dout;
        wait_cycles(1);   // Clear-on-read and latch edge
        release_bus();
    endtask

    task automatic read_check(string name, reg_addr_t addr, bus_word_t expected);
        bus_word_t value;
        bus_read(addr, value);
        check_value(name, 32'(value), 32'(expected));
    endtask

    task automatic dma_word(bus_word_t data);
        ack = 1'b1;
        dtc = 1'b1;
        din = data;
        wait_cycles(1);
        ack = 1'b0;
        dtc = 1'b0;
    endtask

    task automatic finish_dma;
        done_in = 1'b1;
        ack     = 1'b1;
        wait_cycles(1);
        done_in = 1'b0;
        ack     = 1'b0;
    endtask

    task automatic intreq_within(int limit);
        int waited;
        waited = 0;
        while (!intreq && waited < limit) begin
            wait_cycles(1);
            waited++;
        end
        if (!intreq) begin
            $display("intreq did not rise within %0d cycles", limit);
            abort_run();
        end
    endtask

    task automatic apply_reset;
        reset = 1'b1;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
    endtask

    task automatic idle_outputs_low;
        check_value("bus_ack", 32'(bus_ack), 0);
        check_value("req", 32'(req), 0);
        check_value("rdy", 32'(rdy), 0);
        check_value("intreq", 32'(intreq), 0);
        check_value("fifo_overflow", 32'(fifo_overflow), 0);
    endtask

    task automatic registers_after_reset;
        idle_outputs_low();
        read_check("fmv_tcnt", addr_fmv_tcnt, 16'd55);   // Reset value
        bus_write(addr_fma_ivec, 16'h00A5);
        bus_write(addr_fmv_ivec, 16'h0358);
        bus_write(addr_fma_ier, 16'h5A3C);
        bus_write(addr_fmv_ier, 16'hC3E1);
        bus_write(addr_fmv_tcnt, 16'h1234);
        read_check("fma_ivec", addr_fma_ivec, 16'h00A5);
        read_check("fmv_ivec", addr_fmv_ivec, 16'h0358);
        read_check("fma_ier", addr_fma_ier, 16'h5A3C);
        read_check("fmv_ier", addr_fmv_ier, 16'hC3E1);
        read_check("fmv_tcnt", addr_fmv_tcnt, 16'h1234);
        read_check("unused", 15'h1234, 16'h0000);
        bus_write(addr_fma_ier, 16'h0000);
        bus_write(addr_fmv_ier, 16'h0000);
        bus_write(addr_fmv_tcnt, 16'hFFFF);   // Timer parked far out
        bus_write(addr_fmv_trld, 16'h0000);
    endtask

    task automatic start_codes_via_xfer;
        foreach (start_code_words[i]) begin
            bus_write(addr_fmv_xfer, start_code_words[i]);
        end
        wait_cycles(40);
        read_check("fmv_isr", addr_fmv_isr, 16'h0007);   // pic, gop, seq
        read_check("fmv_isr", addr_fmv_isr, 16'h0000);
    endtask

    task automatic dma_routing;
        bus_write(addr_fmv_syscmd, 16'h8000);
        check_value("req", 32'(req), 1);
        check_value("rdy", 32'(rdy), 1);
        // Every byte at or above 80h, so no 00 00 01 prefix can form
        repeat (8) dma_word(16'($random(seed)) | 16'h8080);
        wait_cycles(10);
        read_check("fmv_isr", addr_fmv_isr, 16'h0000);
        finish_dma();
        check_value("req", 32'(req), 0);
        check_value("rdy", 32'(rdy), 0);

        bus_write(addr_fma_cmd, 16'h8000);
        check_value("req", 32'(req), 1);
        foreach (start_code_words[i]) begin
            dma_word(start_code_words[i]);
        end
        wait_cycles(20);
        read_check("fma_cmd", addr_fma_cmd, 16'h8000);
        finish_dma();
        check_value("req", 32'(req), 0);
        read_check("fma_cmd", addr_fma_cmd, 16'h0000);
        read_check("fmv_isr", addr_fmv_isr, 16'h0000);
    endtask

    task automatic timer_and_dclk;
        bus_word_t  high_word;
        bus_word_t  low_word;
        logic [31:0] first_value;
        logic [31:0] second_value;
        bus_write(addr_fmv_trld, 16'h0000);   // Count at zero before the compare changes
        bus_write(addr_fmv_tcnt, 16'h0002);
        bus_write(addr_fmv_trld, 16'h0000);
        // Tick 17 lands 129 to 136 clocks after the TRLD edge
        wait_cycles(125);
        read_check("fmv_isr", addr_fmv_isr, 16'h0000);
        read_check("fma_isr", addr_fma_isr, 16'h0000);   // Sampled at clock 128
        wait_cycles(31);   // Past tick 20
        read_check("fmv_isr", addr_fmv_isr, 16'h0100);   // tim
        read_check("fma_isr", addr_fma_isr, 16'h0100);   // POLL

        bus_read(addr_fma_dclk_high, high_word);
        bus_read(addr_fma_dclk_low, low_word);
        first_value = {high_word, low_word};
        wait_cycles(196);   // Latch edges 200 clocks apart
        bus_read(addr_fma_dclk_high, high_word);
        bus_read(addr_fma_dclk_low, low_word);
        second_value = {high_word, low_word};
        check_value("dclk_delta", second_value - first_value, 32'(200 / dclk_divider));
    endtask

    task automatic interrupt_vectors;
        bus_word_t  scratch;
        bus_word_t  fmv_vector;
        bus_word_t  fma_vector;
        fmv_vector = 16'h05A8;
        fma_vector = 16'h00C7;
        bus_read(addr_fmv_isr, scratch);   // Drop pending timer flags
        bus_read(addr_fma_isr, scratch);
        check_value("intreq", 32'(intreq), 0);
        bus_write(addr_fmv_ier, 16'h0001);
        check_value("intreq", 32'(intreq), 0);
        bus_write(addr_fmv_xfer, 16'h0000);
        bus_write(addr_fmv_xfer, 16'h01B3);
        intreq_within(40);

        bus_write(addr_fmv_ivec, fmv_vector);
        intack = 1'b1;
        wait_cycles(1);
        check_value("dout", 32'(dout), 32'h0000_B5B5);   // Bits 10..3 of 05A8h
        intack = 1'b0;
        bus_read(addr_fmv_isr, scratch);
        check_value("intreq", 32'(intreq), 0);

        bus_read(addr_fma_isr, scratch);
        bus_write(addr_fma_ivec, fma_vector);
        bus_write(addr_fma_ier, 16'h0100);
        intreq_within(200);   // Timer period is 136 clocks
        intack = 1'b1;
        wait_cycles(1);
        check_value("dout", 32'(dout), 32'h0000_C7C7);   // Low byte of 00C7h twice
        intack = 1'b0;
        bus_write(addr_fma_ier, 16'h0000);
        bus_write(addr_fmv_ier, 16'h0000);
    endtask

    task automatic overflow_at_full_rate;
        bus_write(addr_fmv_syscmd, 16'h8000);
        ack = 1'b1;
        dtc = 1'b1;
        repeat (20) begin
            din = 16'($random(seed));
            wait_cycles(1);
        end
        ack = 1'b0;
        dtc = 1'b0;
        wait_cycles(20);
        check_value("fifo_overflow", 32'(fifo_overflow), 0);
        finish_dma();
        apply_reset();
        idle_outputs_low();
    endtask

    initial begin
        seed         = 83935;
        clk          = 1'b0;
        reset        = 1'b1;
        address      = '0;
        din          = '0;
        uds          = 1'b0;
        lds          = 1'b0;
        write_strobe = 1'b0;
        cs           = 1'b0;
        intack       = 1'b0;
        ack          = 1'b0;
        dtc          = 1'b0;
        done_in      = 1'b0;
        apply_reset();

        registers_after_reset();
        start_codes_via_xfer();
        dma_routing();
        timer_and_dclk();
        interrupt_vectors();
        overflow_at_full_rate();

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- testbench/tb_mpeg_host_sva.sv
`timescale 1ns/10ps

module tb_mpeg_host_sva (
    input logic clk,
    input logic reset,
    input logic cs,
    input logic uds,
    input logic lds,
    input logic bus_ack,
    input logic req,
    input logic rdy,
    input logic ack,
    input logic stream_word_valid
);
    logic access;

    assign access = cs && (uds || lds);

    // Acknowledge toggles during an access
    bus_ack_toggles: assert property (@(posedge clk) disable iff (reset)
        (access && bus_ack) |=> !bus_ack)
        else $error("bus_ack stayed high for two cycles during an access");

    req_matches_rdy: assert property (@(posedge clk) req == rdy)
        else $error("req and rdy disagree");

    // Words come only from the CPU bus or from a DMA acknowledge
    no_word_without_source: assert property (@(posedge clk) disable iff (reset)
        !(stream_word_valid && !cs && !ack))
        else $error("stream_word_valid high without cs or ack");

endmodule

bind mpeg_host_registers tb_mpeg_host_sva u_sva (
    .clk(clk), .reset(reset), .cs(cs), .uds(uds), .lds(lds), .bus_ack(bus_ack),
    .req(req), .rdy(rdy), .ack(ack), .stream_word_valid(stream_word_valid)
);

//--- source/mpeg_host_top.sv
`timescale 1ns/10ps

module mpeg_host_top import mpeg_host_pkg::*; #(
    parameter int dclk_divider = 667,
    parameter int fifo_depth   = 16
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [23:1] address,
    input  bus_word_t   din,
    output bus_word_t   dout,
    input  logic        uds,
    input  logic        lds,
    input  logic        write_strobe,
    input  logic        cs,
    output logic        bus_ack,
    output logic        intreq,
    input  logic        intack,
    output logic        req,
    input  logic        ack,
    output logic        rdy,
    input  logic        dtc,
    input  logic        done_in,
    output logic        fifo_overflow
);
    logic       stream_word_valid;
    logic       byte_valid;
    data_byte_t byte_data;
    data_byte_t fifo_data;
    logic       fifo_empty;
    logic       event_sequence_header;
    logic       event_group_of_pictures;
    logic       event_picture;

    mpeg_host_registers #(
        .dclk_divider(dclk_divider)
    ) u_registers (
        .clk, .reset, .address, .din, .dout, .uds, .lds, .write_strobe, .cs,
        .bus_ack, .intreq, .intack, .req, .ack, .rdy, .dtc, .done_in,
        .stream_word_valid,
        .event_sequence_header, .event_group_of_pictures, .event_picture
    );

    mpeg_word_splitter u_splitter (
        .clk, .reset, .stream_word_valid, .din,
        .byte_valid, .byte_data
    );

    // Detector never stalls, so the FIFO drains whenever it holds data
    mpeg_byte_fifo #(
        .fifo_depth(fifo_depth)
    ) u_fifo (
        .clk, .reset,
        .push(byte_valid), .push_data(byte_data), .pop(!fifo_empty),
        .pop_data(fifo_data), .empty(fifo_empty), .full(), .overflow(fifo_overflow)
    );

    mpeg_start_code_detector u_detector (
        .clk, .reset,
        .data_valid(!fifo_empty), .data_byte(fifo_data),
        .event_sequence_header, .event_group_of_pictures, .event_picture
    );

endmodule

//--- source/mpeg_host_registers.sv
`timescale 1ns/10ps

module mpeg_host_registers import mpeg_host_pkg::*; #(
    parameter int dclk_divider = 667
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [23:1] address,
    input  bus_word_t   din,
    output bus_word_t   dout,
    input  logic        uds,
    input  logic        lds,
    input  logic        write_strobe,
    input  logic        cs,
    output logic        bus_ack,
    output logic        intreq,
    input  logic        intack,
    output logic        req,
    input  logic        ack,
    output logic        rdy,
    input  logic        dtc,
    input  logic        done_in,
    output logic        stream_word_valid,
    input  logic        event_sequence_header,
    input  logic        event_group_of_pictures,
    input  logic        event_picture
);
    localparam int div_width   = $clog2(dclk_divider);
    localparam int timer_width = 16 + timer_prescale_log2;

    reg_addr_t              reg_addr;
    logic                   access;
    logic                   write_cycle;
    logic                   read_cycle;
    logic                   xfer_write;
    logic                   dma_word;
    logic                   fma_intreq;
    logic                   fmv_intreq;
    bus_word_t              fma_cmd;
    bus_word_t              fma_ivec;
    bus_word_t              fma_ier;
    bus_word_t              fma_isr;
    interrupt_flags_s       fmv_ier;
    interrupt_flags_s       fmv_isr;
    bus_word_t              fmv_tcnt;
    bus_word_t              fmv_ivec;
    logic [31:0]            dclk;            // 45 kHz decoder clock
    bus_word_t              dclk_low_latch;
    logic [div_width-1:0]   div_count;
    logic                   dclk_tick;
    logic [timer_width-1:0] timer_count;
    logic                   timer_fire;
    logic                   dma_active;
    logic                   dma_for_fma;

    assign reg_addr    = address[15:1];
    assign access      = cs && (uds || lds);
    assign write_cycle = access && bus_ack && write_strobe;
    assign read_cycle  = access && bus_ack && !write_strobe;
    assign xfer_write  = write_cycle && (reg_addr == addr_fmv_xfer);
    assign dma_word    = ack && dtc;

    // FMA-routed words are discarded here
    assign stream_word_valid = (dma_word || xfer_write) && !dma_for_fma;

    assign dclk_tick  = div_count == div_width'(dclk_divider - 1);
    assign timer_fire = dclk_tick
                        && (timer_count[timer_width-1:timer_prescale_log2] == fmv_tcnt);

    assign fma_intreq = |(fma_isr & fma_ier);
    assign fmv_intreq = |(fmv_isr & fmv_ier);
    assign intreq     = fma_intreq || fmv_intreq;
    assign req        = dma_active;
    assign rdy        = dma_active;

    always_comb begin
        dout = '0;
        case (reg_addr)
            addr_fma_cmd:       dout = fma_cmd;
            addr_fma_ivec:      dout = fma_ivec;
            addr_fma_dclk_high: dout = dclk[31:16];
            addr_fma_dclk_low:  dout = dclk_low_latch;
            addr_fma_isr:       dout = fma_isr;
            addr_fma_ier:       dout = fma_ier;
            addr_fmv_ier:       dout = fmv_ier;
            addr_fmv_isr:       dout = fmv_isr;
            addr_fmv_tcnt:      dout = fmv_tcnt;
            addr_fmv_ivec:      dout = fmv_ivec;
            default: ;
        endcase
        // Interrupt acknowledge cycle, FMA has priority
        if (intack) begin
            if (fma_intreq) begin
                dout = {fma_ivec[7:0], fma_ivec[7:0]};
            end else begin
                dout = {fmv_ivec[10:3], fmv_ivec[10:3]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bus_ack <= 1'b0;
        end else begin
            bus_ack <= access && !bus_ack;   // Toggles while the access lasts
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            div_count <= '0;
            dclk      <= '0;
        end else if (dclk_tick) begin
            div_count <= '0;
            dclk      <= dclk + 1'b1;
        end else begin
            div_count <= div_count + 1'b1;
        end
    end

    // Reading DCLK high freezes the low half for the following read
    always_ff @(posedge clk) begin
        if (read_cycle && (reg_addr == addr_fma_dclk_high)) begin
            dclk_low_latch <= dclk[15:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            timer_count <= '0;
        end else if (write_cycle && (reg_addr == addr_fmv_trld)) begin
            timer_count <= '0;
        end else if (timer_fire) begin
            timer_count <= '0;
        end else if (dclk_tick) begin
            timer_count <= timer_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dma_active  <= 1'b0;
            dma_for_fma <= 1'b0;
        end else begin
            if (done_in && ack) begin
                dma_active  <= 1'b0;
                dma_for_fma <= 1'b0;
            end
            if (write_cycle && din[cmd_dma_bit]) begin
                if (reg_addr == addr_fma_cmd) begin
                    dma_active  <= 1'b1;
                    dma_for_fma <= 1'b1;
                end else if (reg_addr == addr_fmv_syscmd) begin
                    dma_active  <= 1'b1;
                    dma_for_fma <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fma_cmd  <= '0;
            fma_ivec <= '0;
            fma_ier  <= '0;
            fmv_ier  <= '0;
            fmv_tcnt <= 16'd55;
            fmv_ivec <= '0;
        end else begin
            if (done_in && ack) begin
                fma_cmd[cmd_dma_bit] <= 1'b0;   // DMA finished
            end
            if (write_cycle) begin
                case (reg_addr)
                    addr_fma_cmd:  fma_cmd  <= din;
                    addr_fma_ivec: fma_ivec <= din;
                    addr_fma_ier:  fma_ier  <= din;
                    addr_fmv_ier:  fmv_ier  <= din;
                    addr_fmv_tcnt: fmv_tcnt <= din;
                    addr_fmv_ivec: fmv_ivec <= din;
                    default: ;
                endcase
            end
        end
    end

    // Status registers clear on read, new events in the same cycle survive
    always_ff @(posedge clk) begin
        if (reset) begin
            fma_isr <= '0;
            fmv_isr <= '0;
        end else begin
            if (read_cycle && (reg_addr == addr_fma_isr)) begin
                fma_isr <= '0;
            end
            if (read_cycle && (reg_addr == addr_fmv_isr)) begin
                fmv_isr <= '0;
            end
            if (event_sequence_header) begin
                fmv_isr.seq <= 1'b1;
            end
            if (event_group_of_pictures) begin
                fmv_isr.gop <= 1'b1;
            end
            if (event_picture) begin
                fmv_isr.pic <= 1'b1;
            end
            if (timer_fire) begin
                fmv_isr.tim               <= 1'b1;
                fma_isr[fma_isr_poll_bit] <= 1'b1;   // POLL
            end
        end
    end

endmodule

//--- source/mpeg_start_code_detector.sv
`timescale 1ns/10ps

module mpeg_start_code_detector import mpeg_host_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       data_valid,
    input  data_byte_t data_byte,
    output logic       event_sequence_header,
    output logic       event_group_of_pictures,
    output logic       event_picture
);
    localparam logic [1:0] run_max = 2'd2;   // Two or more zero bytes

    logic [1:0] zero_run;      // Length of current zero byte run
    logic       prefix_seen;   // 00 00 01 complete, next byte is the code
    logic       code_valid;

    assign code_valid = data_valid && prefix_seen;

    // Events come one clock after the code byte
    always_ff @(posedge clk) begin
        if (reset) begin
            event_sequence_header   <= 1'b0;
            event_group_of_pictures <= 1'b0;
            event_picture           <= 1'b0;
        end else begin
            event_sequence_header   <= code_valid && (data_byte == start_code_seq);
            event_group_of_pictures <= code_valid && (data_byte == start_code_gop);
            event_picture           <= code_valid && (data_byte == start_code_pic);
        end
    end

    // Prefix tracking
    always_ff @(posedge clk) begin
        if (reset) begin
            zero_run    <= 2'd0;
            prefix_seen <= 1'b0;
        end else if (data_valid) begin
            if (prefix_seen) begin
                // Code byte consumed, a 00h code does not count toward a new run
                prefix_seen <= 1'b0;
                zero_run    <= 2'd0;
            end else if (data_byte == start_code_zero) begin
                if (zero_run != run_max) begin
                    zero_run <= zero_run + 2'd1;
                end
            end else begin
                prefix_seen <= (data_byte == start_code_prefix) && (zero_run == run_max);
                zero_run    <= 2'd0;
            end
        end
    end

endmodule

//--- source/mpeg_byte_fifo.sv
`timescale 1ns/10ps

module mpeg_byte_fifo import mpeg_host_pkg::*; #(
    parameter int fifo_depth = 16
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       push,
    input  data_byte_t push_data,
    input  logic       pop,
    output data_byte_t pop_data,
    output logic       empty,
    output logic       full,
    output logic       overflow
);
    localparam int ptr_width   = $clog2(fifo_depth);
    localparam int count_width = $clog2(fifo_depth + 1);

    data_byte_t             mem [fifo_depth];
    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic [count_width-1:0] count;
    logic                   do_push;
    logic                   do_pop;

    assign empty   = count == '0;
    assign full    = count == count_width'(fifo_depth);
    assign do_push = push && !full;     // Push while full is lost
    assign do_pop  = pop && !empty;

    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_width'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_width'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
            if (push && full) begin
                overflow <= 1'b1;   // Sticky until reset
            end
        end
    end

endmodule

//--- source/mpeg_word_splitter.sv
`timescale 1ns/10ps

module mpeg_word_splitter import mpeg_host_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       stream_word_valid,
    input  bus_word_t  din,
    output logic       byte_valid,
    output data_byte_t byte_data
);
    logic       word_valid_q;   // Low byte pending
    data_byte_t low_byte_q;

    // Word strobe delayed by one clock
    always_ff @(posedge clk) begin
        if (reset) begin
            word_valid_q <= 1'b0;
        end else begin
            word_valid_q <= stream_word_valid;
        end
    end

    // Low byte held for the second cycle
    always_ff @(posedge clk) begin
        if (stream_word_valid) begin
            low_byte_q <= din[7:0];
        end
    end

    // High byte goes straight through, held low byte wins the next cycle
    assign byte_valid = word_valid_q || stream_word_valid;
    assign byte_data  = word_valid_q ? low_byte_q : din[15:8];

endmodule

//--- source/mpeg_host_pkg.sv
package mpeg_host_pkg;

    typedef logic [7:0]  data_byte_t;   // One stream byte
    typedef logic [15:0] bus_word_t;    // One CPU data word
    typedef logic [14:0] reg_addr_t;    // Word address, bits 15..1

    // FMV interrupt enable and status layout
    typedef struct packed {
        logic erdv;
        logic erdd;
        logic vcup;
        logic pai;
        logic vsync;
        logic eii;
        logic esi;
        logic tim;     // Programmable timer
        logic dcl;
        logic ovf;
        logic ndat;
        logic rfb;
        logic eod;
        logic pic;     // Picture start code
        logic gop;     // Group of pictures start code
        logic seq;     // Sequence header start code
    } interrupt_flags_s;

    // FMA register block
    localparam reg_addr_t addr_fma_cmd       = 15'h1800;
    localparam reg_addr_t addr_fma_ivec      = 15'h1806;
    localparam reg_addr_t addr_fma_dclk_high = 15'h1808;
    localparam reg_addr_t addr_fma_dclk_low  = 15'h1809;
    localparam reg_addr_t addr_fma_isr       = 15'h180D;
    localparam reg_addr_t addr_fma_ier       = 15'h180E;

    // FMV register block
    localparam reg_addr_t addr_fmv_ier    = 15'h2030;
    localparam reg_addr_t addr_fmv_isr    = 15'h2031;
    localparam reg_addr_t addr_fmv_tcnt   = 15'h2032;
    localparam reg_addr_t addr_fmv_trld   = 15'h2057;
    localparam reg_addr_t addr_fmv_syscmd = 15'h2060;
    localparam reg_addr_t addr_fmv_ivec   = 15'h206E;
    localparam reg_addr_t addr_fmv_xfer   = 15'h206F;

    localparam int fma_isr_poll_bit    = 8;    // POLL flag in FMA ISR
    localparam int cmd_dma_bit         = 15;   // DMA start in command words
    localparam int timer_prescale_log2 = 3;    // Timer compare in units of 8 ticks

    // Video start code bytes
    localparam data_byte_t start_code_zero   = 8'h00;
    localparam data_byte_t start_code_prefix = 8'h01;
    localparam data_byte_t start_code_seq    = 8'hB3;
    localparam data_byte_t start_code_gop    = 8'hB8;
    localparam data_byte_t start_code_pic    = 8'h00;

endpackage
